//--- hw/core_mem_pkg.sv
package core_mem_pkg;

  localparam int NUM_BANKS  = 4;
  localparam int BANK_DEPTH = 1024;
  localparam int NUM_BYTES  = 4;

  // address fields of a word-interleaved local address
  localparam int BANK_SEL_LSB  = 2;
  localparam int BANK_WORD_LSB = 4;
  localparam int LOCAL_TAG_LSB = 24;

  typedef logic [31:0]              addr_t;
  typedef logic [31:0]              data_t;
  typedef logic [NUM_BYTES-1:0]     be_t;
  typedef logic [1:0]               bank_idx_t;
  typedef logic [9:0]               bank_addr_t;

  // one bank access, shared by all banks of a requester
  typedef struct packed {
    bank_addr_t addr;
    logic       we;
    be_t        be;
    data_t      wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    RESP
  } apb_state_t;

  // top byte zero means local ram, bits 23:14 alias
  function automatic logic is_local(addr_t addr);
    return (addr[31:LOCAL_TAG_LSB] == '0);
  endfunction

  function automatic bank_idx_t bank_of(addr_t addr);
    return addr[BANK_SEL_LSB +: $bits(bank_idx_t)];
  endfunction

  function automatic bank_addr_t word_of(addr_t addr);
    return addr[BANK_WORD_LSB +: $bits(bank_addr_t)];
  endfunction

endpackage

//--- hw/lsu_bank_demux.sv
`timescale 1ns/1ns

module lsu_bank_demux
(
  input  logic                                req_i,
  input  core_mem_pkg::addr_t                 addr_i,
  input  logic                                we_i,
  input  core_mem_pkg::be_t                   be_i,
  input  core_mem_pkg::data_t                 wdata_i,
  input  logic [core_mem_pkg::NUM_BANKS-1:0]  bank_gnt_i,

  output logic                                gnt_o,
  output logic [core_mem_pkg::NUM_BANKS-1:0]  bank_req_o,
  output core_mem_pkg::mem_req_t              bank_cmd_o,
  output logic                                err_req_o
);

  logic                    local_addr;
  core_mem_pkg::bank_idx_t bank_idx;

  assign local_addr = core_mem_pkg::is_local(addr_i);
  assign bank_idx   = core_mem_pkg::bank_of(addr_i);

  // same command goes to every bank, only one gets the request bit
  always_comb
  begin
    bank_cmd_o.addr  = core_mem_pkg::word_of(addr_i);
    bank_cmd_o.we    = we_i;
    bank_cmd_o.be    = be_i;
    bank_cmd_o.wdata = wdata_i;
  end

  always_comb
  begin
    bank_req_o = '0;
    if (req_i && local_addr)
    begin
      bank_req_o[bank_idx] = 1'b1;
    end
  end

  // stands in for the external bus: accept at once and flag it
  always_comb
  begin
    if (local_addr)
    begin
      gnt_o = bank_gnt_i[bank_idx];
    end
    else
    begin
      gnt_o = 1'b1;
    end
  end

  assign err_req_o = req_i & ~local_addr;

endmodule

//--- hw/mem_bank.sv
`timescale 1ns/1ns

module mem_bank
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    apb_req_i,
  input  core_mem_pkg::mem_req_t  apb_cmd_i,
  input  logic                    lsu_req_i,
  input  core_mem_pkg::mem_req_t  lsu_cmd_i,

  output logic                    apb_gnt_o,
  output logic                    lsu_gnt_o,
  output core_mem_pkg::data_t     rdata_o,
  output logic                    lsu_rvalid_o
);

  core_mem_pkg::data_t    mem [core_mem_pkg::BANK_DEPTH];
  core_mem_pkg::mem_req_t cmd;
  logic                   ram_en;

  // fixed priority, apb first
  assign apb_gnt_o = apb_req_i;
  assign lsu_gnt_o = lsu_req_i & ~apb_req_i;

  assign ram_en = apb_req_i | lsu_req_i;

  always_comb
  begin
    if (apb_req_i)
    begin
      cmd = apb_cmd_i;
    end
    else
    begin
      cmd = lsu_cmd_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ram_en)
    begin
      if (cmd.we)
      begin
        for (int i = 0; i < core_mem_pkg::NUM_BYTES; i++)
        begin
          if (cmd.be[i])
          begin
            mem[cmd.addr][8*i +: 8] <= cmd.wdata[8*i +: 8];
          end
        end
        // writes answer with zero
        rdata_o <= '0;
      end
      else
      begin
        rdata_o <= mem[cmd.addr];
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      lsu_rvalid_o <= 1'b0;
    end
    else
    begin
      lsu_rvalid_o <= lsu_gnt_o;
    end
  end

endmodule

//--- hw/lsu_resp_router.sv
`timescale 1ns/1ns

module lsu_resp_router
(
  input  logic                                clk,
  input  logic                                rst_n,

  input  logic [core_mem_pkg::NUM_BANKS-1:0]  bank_rvalid_i,
  input  core_mem_pkg::data_t                 bank_rdata_i [core_mem_pkg::NUM_BANKS],
  input  logic                                err_req_i,

  output logic                                rvalid_o,
  output core_mem_pkg::data_t                 rdata_o,
  output logic                                rerr_o
);

  logic err_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      err_q <= 1'b0;
    end
    else
    begin
      err_q <= err_req_i;
    end
  end

  // at most one source is valid per cycle, so a plain OR merge works
  always_comb
  begin
    rdata_o = '0;
    for (int b = 0; b < core_mem_pkg::NUM_BANKS; b++)
    begin
      if (bank_rvalid_i[b])
      begin
        rdata_o = rdata_o | bank_rdata_i[b];
      end
    end
  end

  assign rvalid_o = (|bank_rvalid_i) | err_q;
  assign rerr_o   = err_q;

endmodule

//--- hw/apb_mem_bridge.sv
`timescale 1ns/1ns

module apb_mem_bridge
(
  input  logic                                clk,
  input  logic                                rst_n,

  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  core_mem_pkg::addr_t                 paddr_i,
  input  core_mem_pkg::data_t                 pwdata_i,
  input  core_mem_pkg::be_t                   pstrb_i,
  input  logic [core_mem_pkg::NUM_BANKS-1:0]  bank_gnt_i,
  input  core_mem_pkg::data_t                 bank_rdata_i [core_mem_pkg::NUM_BANKS],

  output logic                                pready_o,
  output core_mem_pkg::data_t                 prdata_o,
  output logic                                pslverr_o,
  output logic [core_mem_pkg::NUM_BANKS-1:0]  bank_req_o,
  output core_mem_pkg::mem_req_t              bank_cmd_o
);

  core_mem_pkg::apb_state_t state_q, state_d;
  core_mem_pkg::bank_idx_t  bank_idx;
  core_mem_pkg::bank_idx_t  bank_idx_q;
  logic                     access;
  logic                     local_addr;

  assign access     = psel_i & penable_i;
  assign local_addr = core_mem_pkg::is_local(paddr_i);
  assign bank_idx   = core_mem_pkg::bank_of(paddr_i);

  always_comb
  begin
    bank_cmd_o.addr  = core_mem_pkg::word_of(paddr_i);
    bank_cmd_o.we    = pwrite_i;
    bank_cmd_o.be    = pstrb_i;
    bank_cmd_o.wdata = pwdata_i;
  end

  always_comb
  begin
    state_d    = state_q;
    bank_req_o = '0;
    pready_o   = 1'b0;
    pslverr_o  = 1'b0;
    prdata_o   = '0;

    case (state_q)
      core_mem_pkg::IDLE:
      begin
        // setup phase
        if (psel_i)
        begin
          state_d = core_mem_pkg::WAIT_GNT;
        end
      end

      core_mem_pkg::WAIT_GNT:
      begin
        if (access && !local_addr)
        begin
          pready_o  = 1'b1;
          pslverr_o = 1'b1;
          state_d   = core_mem_pkg::IDLE;
        end
        else if (access)
        begin
          bank_req_o[bank_idx] = 1'b1;
          if (bank_gnt_i[bank_idx])
          begin
            state_d = core_mem_pkg::RESP;
          end
        end
      end

      core_mem_pkg::RESP:
      begin
        pready_o = 1'b1;
        prdata_o = bank_rdata_i[bank_idx_q];
        state_d  = core_mem_pkg::IDLE;
      end

      default:
      begin
        state_d = core_mem_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      state_q <= core_mem_pkg::IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // bank whose read register holds our data next cycle
  always_ff @(posedge clk)
  begin
    if (state_q == core_mem_pkg::WAIT_GNT)
    begin
      bank_idx_q <= bank_idx;
    end
  end

endmodule

//--- hw/core_mem_region.sv
`timescale 1ns/1ns

module core_mem_region
(
  input  logic                 clk,
  input  logic                 rst_n,

  // core load/store port
  input  logic                 req_i,
  output logic                 gnt_o,
  input  core_mem_pkg::addr_t  addr_i,
  input  logic                 we_i,
  input  core_mem_pkg::be_t    be_i,
  input  core_mem_pkg::data_t  wdata_i,
  output logic                 rvalid_o,
  output core_mem_pkg::data_t  rdata_o,
  output logic                 rerr_o,

  // external apb slave
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  core_mem_pkg::addr_t  paddr_i,
  input  core_mem_pkg::data_t  pwdata_i,
  input  core_mem_pkg::be_t    pstrb_i,
  output logic                 pready_o,
  output core_mem_pkg::data_t  prdata_o,
  output logic                 pslverr_o
);

  logic [core_mem_pkg::NUM_BANKS-1:0] lsu_bank_req;
  logic [core_mem_pkg::NUM_BANKS-1:0] lsu_bank_gnt;
  logic [core_mem_pkg::NUM_BANKS-1:0] apb_bank_req;
  logic [core_mem_pkg::NUM_BANKS-1:0] apb_bank_gnt;
  logic [core_mem_pkg::NUM_BANKS-1:0] bank_rvalid;
  core_mem_pkg::data_t                bank_rdata [core_mem_pkg::NUM_BANKS];
  core_mem_pkg::mem_req_t             lsu_cmd;
  core_mem_pkg::mem_req_t             apb_cmd;
  logic                               err_req;

  lsu_bank_demux u_lsu_demux
  (
    .req_i      ( req_i        ),
    .addr_i     ( addr_i       ),
    .we_i       ( we_i         ),
    .be_i       ( be_i         ),
    .wdata_i    ( wdata_i      ),
    .bank_gnt_i ( lsu_bank_gnt ),
    .gnt_o      ( gnt_o        ),
    .bank_req_o ( lsu_bank_req ),
    .bank_cmd_o ( lsu_cmd      ),
    .err_req_o  ( err_req      )
  );

  for (genvar b = 0; b < core_mem_pkg::NUM_BANKS; b++)
  begin : g_bank
    mem_bank u_bank
    (
      .clk          ( clk             ),
      .rst_n        ( rst_n           ),
      .apb_req_i    ( apb_bank_req[b] ),
      .apb_cmd_i    ( apb_cmd         ),
      .lsu_req_i    ( lsu_bank_req[b] ),
      .lsu_cmd_i    ( lsu_cmd         ),
      .apb_gnt_o    ( apb_bank_gnt[b] ),
      .lsu_gnt_o    ( lsu_bank_gnt[b] ),
      .rdata_o      ( bank_rdata[b]   ),
      .lsu_rvalid_o ( bank_rvalid[b]  )
    );
  end

  lsu_resp_router u_resp_router
  (
    .clk           ( clk         ),
    .rst_n         ( rst_n       ),
    .bank_rvalid_i ( bank_rvalid ),
    .bank_rdata_i  ( bank_rdata  ),
    .err_req_i     ( err_req     ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .rerr_o        ( rerr_o      )
  );

  apb_mem_bridge u_apb_bridge
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .psel_i       ( psel_i       ),
    .penable_i    ( penable_i    ),
    .pwrite_i     ( pwrite_i     ),
    .paddr_i      ( paddr_i      ),
    .pwdata_i     ( pwdata_i     ),
    .pstrb_i      ( pstrb_i      ),
    .bank_gnt_i   ( apb_bank_gnt ),
    .bank_rdata_i ( bank_rdata   ),
    .pready_o     ( pready_o     ),
    .prdata_o     ( prdata_o     ),
    .pslverr_o    ( pslverr_o    ),
    .bank_req_o   ( apb_bank_req ),
    .bank_cmd_o   ( apb_cmd      )
  );

endmodule

//--- sim/core_mem_region_sva.sv
`timescale 1ns/1ns

module core_mem_region_sva
(
  input logic                clk,
  input logic                rst_n,
  input logic                req_i,
  input logic                gnt_o,
  input core_mem_pkg::addr_t addr_i,
  input logic                rvalid_o,
  input logic                rerr_o,
  input logic                psel_i,
  input logic                penable_i,
  input logic                pready_o
);

  int fails = 0;

  // every accepted request answers on the next cycle, and only then
  a_resp_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && gnt_o |=> rvalid_o)
    else
    begin
      fails++;
      $error("rvalid_o missing one cycle after an accepted request");
    end

  a_resp_has_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_o |-> $past(req_i && gnt_o))
    else
    begin
      fails++;
      $error("rvalid_o high without an accepted request one cycle before");
    end

  a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready_o |-> psel_i && penable_i)
    else
    begin
      fails++;
      $error("pready_o high outside an apb access phase");
    end

  // error answers belong to a non-local request one cycle before
  a_err_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rerr_o |-> rvalid_o && $past(addr_i[31:24] != 8'h00))
    else
    begin
      fails++;
      $error("rerr_o high without rvalid_o or a non-local request before it");
    end

endmodule

bind core_mem_region core_mem_region_sva u_sva
(
  .clk       ( clk       ),
  .rst_n     ( rst_n     ),
  .req_i     ( req_i     ),
  .gnt_o     ( gnt_o     ),
  .addr_i    ( addr_i    ),
  .rvalid_o  ( rvalid_o  ),
  .rerr_o    ( rerr_o    ),
  .psel_i    ( psel_i    ),
  .penable_i ( penable_i ),
  .pready_o  ( pready_o  )
);

//--- sim/core_mem_region_tb.sv
`timescale 1ns/1ns

module core_mem_region_tb;

  localparam int POOL_WORDS = 64;
  localparam int N_RANDOM   = 300;
  localparam int N_STREAM   = 64;
  localparam int N_ERR      = 40;
  localparam int N_APB      = 120;
  localparam int N_HAMMER   = 200;
  localparam int N_APB_ERR  = 6;
  localparam int SWEEPS     = 4;
  localparam int CORE_OPS   = POOL_WORDS * (SWEEPS + 1) + N_RANDOM + N_STREAM + N_ERR + N_HAMMER;
  localparam int APB_OPS    = N_APB + N_HAMMER / 4 + N_APB_ERR;
  // an apb transfer with its idle cycle is about four cycles
  localparam int CYCLE_LIMIT = 2 * (CORE_OPS + 4 * APB_OPS) + 200;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
  } resp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  core_mem_pkg::addr_t  addr;
  logic                 we;
  core_mem_pkg::be_t    be;
  core_mem_pkg::data_t  wdata;
  logic                 gnt;
  logic                 rvalid;
  core_mem_pkg::data_t  rdata;
  logic                 rerr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  core_mem_pkg::addr_t  paddr;
  core_mem_pkg::data_t  pwdata;
  core_mem_pkg::be_t    pstrb;
  logic                 pready;
  core_mem_pkg::data_t  prdata;
  logic                 pslverr;

  // reference ram, indexed by address bits 13:2
  logic [31:0] model [4096];
  resp_t       exp_q [$];
  logic [31:0] rng;
  int          cycle;
  int          checks;
  int          errors;
  int          err_base;
  int          test_num;
  int          tests_bad;

  core_mem_region dut
  (
    .clk       ( clk     ),
    .rst_n     ( rst_n   ),
    .req_i     ( req     ),
    .gnt_o     ( gnt     ),
    .addr_i    ( addr    ),
    .we_i      ( we      ),
    .be_i      ( be      ),
    .wdata_i   ( wdata   ),
    .rvalid_o  ( rvalid  ),
    .rdata_o   ( rdata   ),
    .rerr_o    ( rerr    ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .pstrb_i   ( pstrb   ),
    .pready_o  ( pready  ),
    .prdata_o  ( prdata  ),
    .pslverr_o ( pslverr )
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] din,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        res[8*i +: 8] = din[8*i +: 8];
      end
    end
    return res;
  endfunction

  // random alias bits 23:14 on top of the word index
  function automatic core_mem_pkg::addr_t pool_addr(int w);
    logic [31:0] r;
    r = next_random();
    return {8'h00, r[9:0], 12'(w), 2'b00};
  endfunction

  function automatic core_mem_pkg::addr_t remote_addr(int w);
    logic [31:0] r;
    logic [7:0]  top;
    r   = next_random();
    top = (r[31:24] == 8'h00) ? 8'h5a : r[31:24];
    return {top, r[9:0], 12'(w), 2'b00};
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expv);
    checks++;
    assert (got === expv)
    else
    begin
      errors++;
      $display("error t=%0t %s got %h expected %h", $time, name, got, expv);
    end
  endtask

  task automatic core_access(core_mem_pkg::addr_t a, logic w, core_mem_pkg::be_t b,
                             core_mem_pkg::data_t d, output int waits);
    waits = 0;
    @(negedge clk);
    req   = 1'b1;
    addr  = a;
    we    = w;
    be    = b;
    wdata = d;
    @(posedge clk);
    while (!gnt)
    begin
      waits++;
      @(posedge clk);
    end
  endtask

  task automatic apb_transfer(core_mem_pkg::addr_t a, logic w, core_mem_pkg::be_t s,
                              core_mem_pkg::data_t d);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = w;
    paddr   = a;
    pwdata  = d;
    pstrb   = s;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready)
    begin
      @(posedge clk);
    end
    if (a[31:24] != 8'h00)
    begin
      check_value("pslverr_o", pslverr, 1);
    end
    else
    begin
      check_value("pslverr_o", pslverr, 0);
      if (w)
      begin
        model[a[13:2]] = merge_bytes(model[a[13:2]], d, s);
      end
      else
      begin
        check_value("prdata_o", prdata, model[a[13:2]]);
      end
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // reads every pool word back through the core port
  task automatic sweep_pool();
    int waits;
    for (int w = 0; w < POOL_WORDS; w++)
    begin
      core_access(pool_addr(w), 1'b0, '0, '0, waits);
    end
  endtask

  task automatic finish_test(string name);
    @(negedge clk);
    req = 1'b0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
    end
    test_num++;
    if (errors != err_base)
    begin
      tests_bad++;
    end
    $display("test %0d %s: %0d errors", test_num, name, errors - err_base);
    err_base = errors;
  endtask

  // response checker and expected-response queue, one step per cycle
  always @(posedge clk)
  begin
    resp_t exp;
    cycle = cycle + 1;
    if (rst_n)
    begin
      assert (rvalid || exp_q.size() == 0)
      else
      begin
        errors++;
        $display("error t=%0t no response one cycle after a grant", $time);
      end
      assert (!rvalid || exp_q.size() != 0)
      else
      begin
        errors++;
        $display("error t=%0t response with no request in flight", $time);
      end
      if (exp_q.size() != 0)
      begin
        exp = exp_q.pop_front();
        if (rvalid)
        begin
          check_value("rdata_o", rdata, exp.data);
          check_value("rerr_o", rerr, exp.err);
        end
      end
      if (req && gnt)
      begin
        exp.err  = (addr[31:24] != 8'h00);
        exp.data = '0;
        if (!exp.err && we)
        begin
          model[addr[13:2]] = merge_bytes(model[addr[13:2]], wdata, be);
        end
        else if (!exp.err)
        begin
          exp.data = model[addr[13:2]];
        end
        exp_q.push_back(exp);
      end
    end
  end

  initial
  begin
    wait (cycle > CYCLE_LIMIT);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int          waits;
    int          hammer_waits;
    logic [31:0] r;
    logic [31:0] d;

    rst_n   = 1'b0;
    req     = 1'b0;
    addr    = '0;
    we      = 1'b0;
    be      = '0;
    wdata   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    rng     = 32'h1bda_7914;
    cycle   = 0;
    checks  = 0;
    errors  = 0;
    err_base  = 0;
    test_num  = 0;
    tests_bad = 0;
    hammer_waits = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // full words first so no byte of the pool is unknown
    for (int w = 0; w < POOL_WORDS; w++)
    begin
      d = next_random();
      core_access(pool_addr(w), 1'b1, 4'hf, d, waits);
    end
    for (int i = 0; i < N_RANDOM; i++)
    begin
      r = next_random();
      d = next_random();
      core_access(pool_addr(r[5:0]), r[31], r[11:8], d, waits);
    end
    finish_test("core random write/read");

    for (int i = 0; i < N_STREAM; i++)
    begin
      r = next_random();
      core_access(pool_addr({r[5:2], 2'(i)}), 1'b0, '0, '0, waits);
      checks++;
      assert (waits == 0)
      else
      begin
        errors++;
        $display("error t=%0t idle bank held a streamed request %0d cycles", $time, waits);
      end
    end
    finish_test("core back-to-back banks");

    for (int i = 0; i < N_ERR; i++)
    begin
      r = next_random();
      d = next_random();
      core_access(remote_addr(r[5:0]), r[31], r[11:8], d, waits);
    end
    sweep_pool();
    finish_test("core non-local error");

    for (int i = 0; i < N_APB; i++)
    begin
      r = next_random();
      d = next_random();
      apb_transfer(pool_addr(r[5:0]), r[31], r[11:8], d);
    end
    sweep_pool();
    finish_test("apb random write/read");

    // core and apb share bank 2 on disjoint words
    fork
      begin
        logic [31:0] cr;
        logic [31:0] cd;
        int          core_waits;
        for (int i = 0; i < N_HAMMER; i++)
        begin
          cr = next_random();
          cd = next_random();
          core_access(pool_addr({cr[5:3], 3'b010}), cr[31], cr[11:8], cd, core_waits);
          hammer_waits += core_waits;
        end
      end
      begin
        logic [31:0] ar;
        logic [31:0] ad;
        for (int i = 0; i < N_HAMMER / 4; i++)
        begin
          ar = next_random();
          ad = next_random();
          apb_transfer(pool_addr({ar[5:3], 3'b110}), ar[31], ar[11:8], ad);
        end
      end
    join
    checks++;
    assert (hammer_waits > 0)
    else
    begin
      errors++;
      $display("error t=%0t core grant never dropped while apb held the bank", $time);
    end
    sweep_pool();
    finish_test("apb and core on one bank");

    for (int i = 0; i < N_APB_ERR; i++)
    begin
      r = next_random();
      d = next_random();
      apb_transfer(remote_addr(r[5:0]), r[31], 4'hf, d);
    end
    sweep_pool();
    finish_test("apb non-local slave error");

    errors = errors + dut.u_sva.fails;
    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             test_num, tests_bad, checks, errors);
    if (errors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- all.f
hw/core_mem_pkg.sv
hw/lsu_bank_demux.sv
hw/mem_bank.sv
hw/lsu_resp_router.sv
hw/apb_mem_bridge.sv
hw/core_mem_region.sv
sim/core_mem_region_sva.sv
sim/core_mem_region_tb.sv
